// File: compile.f
rtl/base_pkg.sv
rtl/joy_db9.sv
rtl/sd_dac.sv
rtl/spi_rom_loader.sv
rtl/rgb2ypbpr.sv
rtl/video_out.sv
rtl/platform_base.sv
testbench/tb_clock.sv
testbench/platform_base_checker.sv
testbench/tb_platform_base.sv

// File: run.sh
#!/bin/sh
# Build and run the platform_base testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_platform_base \
    -f compile.f \
    -o sim_platform_base
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_platform_base)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: testbench/tb_platform_base.sv
// Testbench for platform_base covering video, sync, ROM load, joysticks, sound and status
`timescale 1ns/1ns

module tb_platform_base;

    import base_pkg::*;

    localparam int JDIV  = 4;
    localparam int FRAME = (2 * JOY_BITS + 2) * JDIV;   // Cycles per joystick frame
    localparam int TOTAL = 7 * 2 + 64 * 2 + 12 * 132 + 3 * 20 + 3 * 3 * FRAME
                         + 3 * 4100 + 8 * 2 + 12;
    localparam int CYCLE_LIMIT = TOTAL * 3 / 2;

    typedef struct packed {
        logic        ypbpr;
        logic        enb;
        logic        rnd;                       // Colours drawn from the LFSR
        logic [11:0] game;
        logic [17:0] scan;
    } vid_row_t;

    typedef struct packed {
        logic [3:0]  en;
        logic [31:0] status;
        logic        enb;
    } stat_row_t;

    logic clk;
    logic rst_n;
    logic [11:0] game_rgb;
    video_sync_t game_sync;
    rgb6_t       scan2x_rgb;
    video_sync_t scan2x_sync;
    logic [3:0]  vgactrl_en;
    logic        ypbpr_en;
    logic [15:0] snd_left;
    logic [15:0] snd_right;
    logic        sd_cs_n;
    logic        sd_clk;
    logic        sd_mosi;
    logic        joy_data = 1'b1;
    logic        lhbl;
    logic        lvbl;
    logic        scan2x_enb;
    video_pxl_u  video;
    logic        video_hs;
    logic        video_vs;
    logic        snd_pwm_left;
    logic        snd_pwm_right;
    logic [21:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        downloading;
    logic        joy_clk;
    logic        joy_load;
    logic [31:0] joystick1;
    logic [31:0] joystick2;
    logic [31:0] status;

    logic [15:0] lfsr = 16'd14153;
    logic [23:0] cur_pat = '1;                  // Pin levels of the external register
    int          bit_idx = 0;
    logic        joy_clk_q = 1'b0;
    int          cycles = 0;
    int          mismatches = 0;
    int          failures = 0;
    logic [7:0]  got_data [$];                  // Every ioctl write seen
    logic [21:0] got_addr [$];

    vid_row_t vid_tab [7] = '{
        '{1'b0, 1'b1, 1'b0, 12'h5A3, 18'h00000},
        '{1'b0, 1'b0, 1'b0, 12'h000, 18'h3F0C1},
        '{1'b1, 1'b1, 1'b0, 12'hFFF, 18'h00000},
        '{1'b1, 1'b0, 1'b0, 12'h000, 18'h3FFFF},
        '{1'b0, 1'b1, 1'b1, 12'h000, 18'h00000},
        '{1'b1, 1'b0, 1'b1, 12'h000, 18'h00000},
        '{1'b1, 1'b1, 1'b1, 12'h000, 18'h00000}
    };

    stat_row_t stat_tab [8] = '{
        '{4'b0000, 32'h0000_0000, 1'b0},
        '{4'b0001, 32'h0000_0000, 1'b1},
        '{4'b0010, 32'h0000_0008, 1'b0},
        '{4'b0100, 32'h0000_1000, 1'b0},
        '{4'b1000, 32'h0000_0040, 1'b0},
        '{4'b1111, 32'h0000_1048, 1'b1},
        '{4'b1010, 32'h0000_0048, 1'b0},
        '{4'b0101, 32'h0000_1000, 1'b1}
    };

    int          rom_len [3] = '{3, 5, 4};
    logic [15:0] snd_tab [3] = '{16'h0000, 16'h9000, 16'h3A7C};

    tb_clock #(.PERIOD(40), .RST_CYCLES(10)) i_tb_clock (.clk(clk), .rst_n(rst_n));

    platform_base #(
        .COLORW     ( 4    ),
        .SIGNED_SND ( 1'b1 ),
        .STEREO     ( 1'b0 ),
        .JOY_DIV    ( JDIV )
    ) i_platform_base (
        .clk_sys(clk), .rst_n(rst_n), .game_rgb(game_rgb), .game_sync(game_sync),
        .lhbl(lhbl), .lvbl(lvbl), .scan2x_rgb(scan2x_rgb), .scan2x_sync(scan2x_sync),
        .vgactrl_en(vgactrl_en), .ypbpr_en(ypbpr_en), .scan2x_enb(scan2x_enb),
        .video(video), .video_hs(video_hs), .video_vs(video_vs),
        .snd_left(snd_left), .snd_right(snd_right), .snd_pwm_left(snd_pwm_left),
        .snd_pwm_right(snd_pwm_right), .sd_cs_n(sd_cs_n), .sd_clk(sd_clk),
        .sd_mosi(sd_mosi), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .ioctl_wr(ioctl_wr), .downloading(downloading), .joy_data(joy_data),
        .joy_clk(joy_clk), .joy_load(joy_load), .joystick1(joystick1),
        .joystick2(joystick2), .status(status)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [5:0] widen4(input logic [3:0] c);
        return {c, c[3:2]};
    endfunction

    // Expected output word from the widening, selection and YPbPr rules
    function automatic logic [17:0] expect_video(input logic [11:0] game,
                                                 input logic [17:0] scan,
                                                 input logic enb, input logic ypb);
        logic [17:0] src;
        int r;
        int g;
        int b;
        int y;
        int pb;
        int pr;
        src = enb ? {widen4(game[11:8]), widen4(game[7:4]), widen4(game[3:0])} : scan;
        r   = int'(src[17:12]);
        g   = int'(src[11:6]);
        b   = int'(src[5:0]);
        y   = (19 * r + 38 * g + 7 * b) / 64;
        pb  = (2048 - 11 * r - 21 * g + 32 * b) / 64;
        pr  = (2048 + 32 * r - 27 * g - 5 * b) / 64;
        return ypb ? {pr[5:0], y[5:0], pb[5:0]} : src;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        mismatches++;
        $display("mismatch %s expected %h actual %h", name, exp, act);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("%s", what);
    endtask

    // External DB9 shift register, answers on the falling edge
    always @(negedge clk)
    begin
        if (joy_load)
            bit_idx = 0;
        else if (joy_clk && !joy_clk_q && bit_idx < JOY_BITS)
            bit_idx++;
        joy_clk_q = joy_clk;
        joy_data  = (bit_idx < JOY_BITS) ? cur_pat[bit_idx] : 1'b1;
    end

    always @(negedge clk)
    begin
        if (ioctl_wr)
        begin
            got_data.push_back(ioctl_data);
            got_addr.push_back(ioctl_addr);
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, tests did not finish", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic run_video();
        vid_row_t    row;
        logic [17:0] exp;
        for (int i = 0; i < 7; i++)
        begin
            row = vid_tab[i];
            if (row.rnd)
            begin
                row.game = 12'(rand_bits(12));
                row.scan = 18'(rand_bits(18));
            end
            game_rgb   = row.game;
            scan2x_rgb = row.scan;
            vgactrl_en = {3'b000, row.enb};
            ypbpr_en   = row.ypbpr;
            @(negedge clk);
            exp = expect_video(row.game, row.scan, row.enb, row.ypbpr);
            assert (video === exp)
                else report_mismatch($sformatf("video row %0d", i), 32'(exp), 32'(video));
            @(negedge clk);
        end
    endtask

    task automatic run_sync();
        logic [1:0] sel;
        logic [1:0] exp;
        logic       cs;
        for (int i = 0; i < 64; i++)
        begin
            vgactrl_en  = {3'b000, i[0]};
            ypbpr_en    = i[1];
            game_sync   = i[3:2];
            scan2x_sync = i[5:4];
            @(negedge clk);
            sel = i[0] ? ~i[3:2] : i[5:4];      // Game sync arrives active high
            cs  = ~(sel[1] ^ sel[0]);
            exp = (i[0] || i[1]) ? {cs, 1'b1} : sel;
            assert ({video_hs, video_vs} === exp)
                else report_mismatch($sformatf("sync combo %0d", i), 32'(exp),
                                     32'({video_hs, video_vs}));
        end
    endtask

    task automatic spi_bit(input logic b);
        sd_mosi = b;
        repeat (8) @(negedge clk);
        sd_clk = 1'b1;
        repeat (8) @(negedge clk);
        sd_clk = 1'b0;
    endtask

    task automatic run_rom();
        logic [7:0] bytes [$];
        int         base;
        for (int r = 0; r < 3; r++)
        begin
            bytes.delete();
            base    = got_data.size();
            sd_cs_n = 1'b0;
            repeat (4) @(negedge clk);
            for (int n = 0; n < rom_len[r]; n++)
            begin
                bytes.push_back(8'(rand_bits(8)));
                for (int k = 7; k >= 0; k--)
                    spi_bit(bytes[n][k]);       // MSB first
                repeat (4) @(negedge clk);
            end
            repeat (4) @(negedge clk);
            assert (downloading === 1'b1)
                else report_failure($sformatf("downloading low inside window %0d", r));
            sd_cs_n = 1'b1;
            repeat (6) @(negedge clk);
            assert (downloading === 1'b0)
                else report_failure($sformatf("downloading still high after window %0d", r));
            assert (got_data.size() - base == rom_len[r])
                else report_mismatch($sformatf("rom row %0d write count", r),
                                     32'(rom_len[r]), 32'(got_data.size() - base));
            for (int n = 0; n < rom_len[r] && base + n < got_data.size(); n++)
            begin
                assert (got_data[base + n] === bytes[n])
                    else report_mismatch($sformatf("rom row %0d byte %0d data", r, n),
                                         32'(bytes[n]), 32'(got_data[base + n]));
                assert (got_addr[base + n] === 22'(n))
                    else report_mismatch($sformatf("rom row %0d byte %0d addr", r, n),
                                         32'(n), 32'(got_addr[base + n]));
            end
        end
    endtask

    task automatic wait_load_rises(input int n);
        int   cnt;
        logic prev;
        cnt  = 0;
        prev = joy_load;
        while (cnt < n)
        begin
            @(negedge clk);
            if (joy_load && !prev)
                cnt++;
            prev = joy_load;
        end
    endtask

    task automatic run_joy();
        logic [23:0] joy_tab [3];
        for (int i = 0; i < 3; i++)
            joy_tab[i] = 24'(rand_bits(24));
        for (int i = 0; i < 3; i++)
        begin
            cur_pat = joy_tab[i];
            wait_load_rises(3);                 // Partial frame, then two whole ones
            assert (joystick1 === {20'd0, ~cur_pat[11:0]})
                else report_mismatch($sformatf("joystick1 row %0d", i),
                                     {20'd0, ~cur_pat[11:0]}, joystick1);
            assert (joystick2 === {20'd0, ~cur_pat[23:12]})
                else report_mismatch($sformatf("joystick2 row %0d", i),
                                     {20'd0, ~cur_pat[23:12]}, joystick2);
        end
    endtask

    task automatic run_sound();
        int   cnt;
        int   u;
        logic same;
        for (int i = 0; i < 3; i++)
        begin
            snd_left  = snd_tab[i];
            snd_right = ~snd_tab[i];            // Ignored in mono build
            cnt  = 0;
            same = 1'b1;
            u    = int'(snd_tab[i] ^ 16'h8000);
            repeat (4096)
            begin
                @(negedge clk);
                cnt += int'(snd_pwm_left);
                if (snd_pwm_right !== snd_pwm_left)
                    same = 1'b0;
            end
            assert (cnt * 16 - u <= 16 && u - cnt * 16 <= 16)
                else report_mismatch($sformatf("sound row %0d ones", i), 32'(u / 16), 32'(cnt));
            assert (same)
                else report_failure($sformatf("snd_pwm_right differs from left, row %0d", i));
        end
    endtask

    task automatic run_status();
        for (int i = 0; i < 8; i++)
        begin
            vgactrl_en = stat_tab[i].en;
            @(negedge clk);
            assert (status === stat_tab[i].status)
                else report_mismatch($sformatf("status row %0d", i), stat_tab[i].status, status);
            assert (scan2x_enb === stat_tab[i].enb)
                else report_mismatch($sformatf("scan2x_enb row %0d", i),
                                     32'(stat_tab[i].enb), 32'(scan2x_enb));
        end
    endtask

    initial
    begin
        game_rgb    = '0;
        game_sync   = '0;
        scan2x_rgb  = '0;
        scan2x_sync = '1;
        vgactrl_en  = 4'b0001;
        ypbpr_en    = 1'b0;
        snd_left    = '0;
        snd_right   = '0;
        sd_cs_n     = 1'b1;
        sd_clk      = 1'b0;
        sd_mosi     = 1'b0;
        lhbl        = 1'b1;                     // Active area, no blanking
        lvbl        = 1'b1;
        wait (rst_n);
        @(negedge clk);
        run_video();
        run_sync();
        run_rom();
        run_joy();
        run_sound();
        run_status();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: testbench/platform_base_checker.sv
// Protocol checker bound into platform_base for ioctl, joystick reset and sync rules
`timescale 1ns/1ns

module platform_base_checker (
    input logic        clk_sys,
    input logic        rst_n,
    input logic        ioctl_wr,
    input logic        downloading,
    input logic [31:0] joystick1,
    input logic [31:0] joystick2,
    input logic        scan2x_enb,
    input logic        ypbpr_en,
    input logic        video_vs
);

    a_wr_in_window : assert property (@(posedge clk_sys) disable iff (!rst_n)
        ioctl_wr |-> downloading)
        else $error("ioctl write seen outside the download window");

    a_wr_single : assert property (@(posedge clk_sys) disable iff (!rst_n)
        ioctl_wr |=> !ioctl_wr)
        else $error("ioctl write strobe longer than one cycle");

    // Button words cleared by reset
    a_joy_reset : assert property (@(posedge clk_sys)
        !rst_n |=> (joystick1 == 32'd0 && joystick2 == 32'd0))
        else $error("joystick words not zero during reset");

    a_vs_high : assert property (@(posedge clk_sys) disable iff (!rst_n)
        (scan2x_enb || ypbpr_en) |=> video_vs)
        else $error("video_vs low in composite sync mode");

endmodule

bind platform_base platform_base_checker i_platform_base_checker (
    .clk_sys     ( clk_sys     ),
    .rst_n       ( rst_n       ),
    .ioctl_wr    ( ioctl_wr    ),
    .downloading ( downloading ),
    .joystick1   ( joystick1   ),
    .joystick2   ( joystick2   ),
    .scan2x_enb  ( scan2x_enb  ),
    .ypbpr_en    ( ypbpr_en    ),
    .video_vs    ( video_vs    )
);

// File: testbench/tb_clock.sv
// Testbench clock and reset source, 40 ns period with reset held for 10 cycles
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                           // Released on a falling edge
    end

endmodule

// File: rtl/platform_base.sv
// Board base layer with joysticks, sound DACs, SPI ROM loading and final video
`timescale 1ns/1ns

module platform_base #(
    parameter int COLORW     = 4,
    parameter bit SIGNED_SND = 1'b1,
    parameter bit STEREO     = 1'b0,
    parameter int JOY_DIV    = 4
) (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    // Game video
    input  logic [3*COLORW-1:0]   game_rgb,
    input  base_pkg::video_sync_t game_sync,
    input  logic                  lhbl,
    input  logic                  lvbl,
    // Scan doubler and video mode
    input  base_pkg::rgb6_t       scan2x_rgb,
    input  base_pkg::video_sync_t scan2x_sync,
    input  logic [3:0]            vgactrl_en,
    input  logic                  ypbpr_en,
    output logic                  scan2x_enb,
    output base_pkg::video_pxl_u  video,
    output logic                  video_hs,
    output logic                  video_vs,
    // Sound
    input  logic [15:0]           snd_left,
    input  logic [15:0]           snd_right,
    output logic                  snd_pwm_left,
    output logic                  snd_pwm_right,
    // ROM download
    input  logic                  sd_cs_n,
    input  logic                  sd_clk,
    input  logic                  sd_mosi,
    output logic [21:0]           ioctl_addr,
    output logic [ 7:0]           ioctl_data,
    output logic                  ioctl_wr,
    output logic                  downloading,
    // Joysticks and switches
    input  logic                  joy_data,
    output logic                  joy_clk,
    output logic                  joy_load,
    output logic [31:0]           joystick1,
    output logic [31:0]           joystick2,
    output logic [31:0]           status
);

    import base_pkg::*;

    joy_state_t          joy1;
    joy_state_t          joy2;
    logic [3*COLORW-1:0] game_rgb_bl;           // Blanked game colour

    assign scan2x_enb  = vgactrl_en[0];         // 0 routes the scan doubler out
    assign game_rgb_bl = (lhbl && lvbl) ? game_rgb : '0;   // Black outside active area
    assign joystick1   = 32'(joy1);
    assign joystick2   = 32'(joy2);

    always_comb
    begin
        status     = '0;
        status[3]  = vgactrl_en[1];             // Scanlines
        status[6]  = vgactrl_en[3];             // Service mode
        status[12] = vgactrl_en[2];             // Screen flip
    end

    joy_db9 #(.JOY_DIV(JOY_DIV)) u_joy_db9 (
        .clk_sys  ( clk_sys  ),
        .rst_n    ( rst_n    ),
        .joy_data ( joy_data ),
        .joy_clk  ( joy_clk  ),
        .joy_load ( joy_load ),
        .joy1     ( joy1     ),
        .joy2     ( joy2     )
    );

    sd_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_left (
        .clk_sys ( clk_sys      ),
        .rst_n   ( rst_n        ),
        .pcm     ( snd_left     ),
        .dac_out ( snd_pwm_left )
    );

    generate
        if (STEREO)
        begin : g_stereo
            sd_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_right (
                .clk_sys ( clk_sys       ),
                .rst_n   ( rst_n         ),
                .pcm     ( snd_right     ),
                .dac_out ( snd_pwm_right )
            );
        end
        else
        begin : g_mono
            assign snd_pwm_right = snd_pwm_left;    // Mono game on both pins
        end
    endgenerate

    spi_rom_loader u_spi_rom_loader (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .sd_cs_n     ( sd_cs_n     ),
        .sd_clk      ( sd_clk      ),
        .sd_mosi     ( sd_mosi     ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .downloading ( downloading )
    );

    video_out #(.COLORW(COLORW)) u_video_out (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .game_rgb    ( game_rgb_bl ),
        .game_sync   ( game_sync   ),
        .scan2x_rgb  ( scan2x_rgb  ),
        .scan2x_sync ( scan2x_sync ),
        .scan2x_enb  ( scan2x_enb  ),
        .ypbpr_en    ( ypbpr_en    ),
        .video       ( video       ),
        .video_hs    ( video_hs    ),
        .video_vs    ( video_vs    )
    );

endmodule

// File: rtl/video_out.sv
// Video output stage with colour widening, source and sync selection and YPbPr
`timescale 1ns/1ns

module video_out #(
    parameter int COLORW = 4                    // Game bits per channel, 3 to 8
) (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic [3*COLORW-1:0]   game_rgb,     // {r, g, b}
    input  base_pkg::video_sync_t game_sync,    // Active high
    input  base_pkg::rgb6_t       scan2x_rgb,
    input  base_pkg::video_sync_t scan2x_sync,  // Active low
    input  logic                  scan2x_enb,   // 1 selects game video
    input  logic                  ypbpr_en,
    output base_pkg::video_pxl_u  video,
    output logic                  video_hs,
    output logic                  video_vs
);

    import base_pkg::*;

    rgb6_t       game_rgb6;
    rgb6_t       src_rgb;
    video_pxl_u  yuv_pxl;
    video_pxl_u  pxl_nxt;
    video_sync_t sel_sync;                      // Active low after selection
    logic        csync;
    logic        sync_mix;                      // Composite on hs, vs tied high

    // Top bits repeated to fill six
    function automatic logic [5:0] widen(input logic [COLORW-1:0] c);
        logic [3*COLORW-1:0] rep;
        rep = {3{c}};
        return rep[3*COLORW-1 -: 6];
    endfunction

    assign game_rgb6.r = widen(game_rgb[3*COLORW-1 -: COLORW]);
    assign game_rgb6.g = widen(game_rgb[2*COLORW-1 -: COLORW]);
    assign game_rgb6.b = widen(game_rgb[COLORW-1:0]);

    assign src_rgb  = scan2x_enb ? game_rgb6 : scan2x_rgb;
    assign sel_sync = scan2x_enb ? video_sync_t'(~game_sync) : scan2x_sync;
    assign csync    = ~(sel_sync.hs ^ sel_sync.vs);
    assign sync_mix = scan2x_enb | ypbpr_en;

    rgb2ypbpr u_rgb2ypbpr (
        .rgb   ( src_rgb ),
        .ypbpr ( yuv_pxl )
    );

    always_comb
    begin
        pxl_nxt.rgb = src_rgb;
        if (ypbpr_en)
            pxl_nxt = yuv_pxl;                  // Component view on the same pins
    end

    always_ff @(posedge clk_sys)
    begin
        if (!rst_n)
        begin
            video    <= '0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
        end
        else
        begin
            video    <= pxl_nxt;
            video_hs <= sync_mix ? csync : sel_sync.hs;
            video_vs <= sync_mix ? 1'b1 : sel_sync.vs;   // High puts SCART in RGB mode
        end
    end

endmodule

// File: rtl/rgb2ypbpr.sv
// RGB to YPbPr converter with fixed integer weights on 6-bit channels
`timescale 1ns/1ns

module rgb2ypbpr (
    input  base_pkg::rgb6_t      rgb,
    output base_pkg::video_pxl_u ypbpr
);

    logic [11:0] r12;
    logic [11:0] g12;
    logic [11:0] b12;
    logic [11:0] y_sum;                         // Weights sum to 64
    logic [11:0] pb_sum;
    logic [11:0] pr_sum;

    assign r12 = 12'(rgb.r);
    assign g12 = 12'(rgb.g);
    assign b12 = 12'(rgb.b);

    // All three land in 0..4064, wrap in between is harmless
    assign y_sum  = 12'd19 * r12 + 12'd38 * g12 + 12'd7 * b12;
    assign pb_sum = 12'd2048 - 12'd11 * r12 - 12'd21 * g12 + 12'd32 * b12;
    assign pr_sum = 12'd2048 + 12'd32 * r12 - 12'd27 * g12 - 12'd5 * b12;

    // Divide by 64
    always_comb
    begin
        ypbpr.ypbpr.pr = pr_sum[11:6];
        ypbpr.ypbpr.y  = y_sum[11:6];
        ypbpr.ypbpr.pb = pb_sum[11:6];
    end

endmodule

// File: rtl/spi_rom_loader.sv
// SPI ROM loader receiving bytes from the I/O controller as ioctl writes
`timescale 1ns/1ns

module spi_rom_loader (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        sd_cs_n,
    input  logic        sd_clk,
    input  logic        sd_mosi,
    output logic [21:0] ioctl_addr,
    output logic [ 7:0] ioctl_data,
    output logic        ioctl_wr,
    output logic        downloading
);

    logic [1:0] cs_sync;                        // Two-flop synchronisers
    logic [2:0] clk_sync;                       // Extra stage for edge detect
    logic [1:0] mosi_sync;
    logic [6:0] byte_sr;                        // First seven bits, MSB first
    logic [2:0] bit_cnt;
    logic       clk_rise;
    logic       cs_act;

    assign cs_act      = ~cs_sync[1];
    assign clk_rise    = clk_sync[1] & ~clk_sync[2];   // Mode 0 sample edge
    assign downloading = cs_act;

    always_ff @(posedge clk_sys)
    begin
        if (!rst_n)
        begin
            cs_sync   <= 2'b11;                 // Deselected
            clk_sync  <= '0;
            mosi_sync <= '0;
        end
        else
        begin
            cs_sync   <= {cs_sync[0], sd_cs_n};
            clk_sync  <= {clk_sync[1:0], sd_clk};
            mosi_sync <= {mosi_sync[0], sd_mosi};   // Same delay as sd_clk
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (!rst_n)
        begin
            bit_cnt    <= '0;
            ioctl_addr <= '0;
            ioctl_wr   <= 1'b0;
        end
        else
        begin
            ioctl_wr <= 1'b0;                   // One-cycle strobe
            if (!cs_act)
            begin
                bit_cnt    <= '0;               // Rising CS ends the load
                ioctl_addr <= '0;
            end
            else
            begin
                if (ioctl_wr)
                    ioctl_addr <= ioctl_addr + 1'b1;
                if (clk_rise)
                begin
                    bit_cnt <= bit_cnt + 1'b1;  // Wraps every byte
                    if (bit_cnt == 3'd7)
                        ioctl_wr <= 1'b1;
                end
            end
        end
    end

    // Byte assembly
    always_ff @(posedge clk_sys)
    begin
        if (cs_act && clk_rise)
        begin
            byte_sr <= {byte_sr[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7)
                ioctl_data <= {byte_sr, mosi_sync[1]};
        end
    end

endmodule

// File: rtl/sd_dac.sv
// First-order sigma-delta DAC turning 16-bit PCM into a 1-bit density stream
`timescale 1ns/1ns

module sd_dac #(
    parameter bit SIGNED_SND = 1'b1             // PCM in two's complement
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [15:0] pcm,
    output logic        dac_out
);

    logic [15:0] pcm_u;                         // Offset binary sample
    logic [15:0] acc;                           // Running residue
    logic [16:0] acc_sum;

    // Two's complement to offset binary is just an MSB flip
    assign pcm_u   = {pcm[15] ^ SIGNED_SND, pcm[14:0]};
    assign acc_sum = {1'b0, acc} + {1'b0, pcm_u};

    always_ff @(posedge clk_sys)
    begin
        if (!rst_n)
        begin
            acc     <= '0;
            dac_out <= 1'b0;
        end
        else
        begin
            acc     <= acc_sum[15:0];           // Keep the remainder
            dac_out <= acc_sum[16];             // Carry out is the stream
        end
    end

endmodule

// File: rtl/joy_db9.sv
// DB9 joystick reader clocking the external shift register for two players
`timescale 1ns/1ns

module joy_db9 #(
    parameter int JOY_DIV = 4                   // clk_sys cycles per half joy_clk period
) (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  logic                 joy_data,
    output logic                 joy_clk,
    output logic                 joy_load,
    output base_pkg::joy_state_t joy1,
    output base_pkg::joy_state_t joy2
);

    import base_pkg::*;

    localparam int PBITS     = JOY_BITS / 2;        // Bits per player
    localparam int LAST_HALF = 2 * JOY_BITS + 1;    // Two load halves, then two per bit
    localparam int DIVW      = $clog2(JOY_DIV + 1);
    localparam int HALFW     = $clog2(LAST_HALF + 1);

    logic [DIVW-1:0]     div_cnt;
    logic [HALFW-1:0]    half_cnt;              // Half periods into the frame
    logic [HALFW-1:0]    half_nxt;
    logic [JOY_BITS-1:0] frame_sr;              // Frame bit 0 lands at the bottom
    logic                half_tick;

    assign half_tick = div_cnt == DIVW'(JOY_DIV - 1);
    assign half_nxt  = (half_cnt == HALFW'(LAST_HALF)) ? '0 : half_cnt + 1'b1;

    always_ff @(posedge clk_sys)
    begin
        if (!rst_n)
        begin
            div_cnt  <= '0;
            half_cnt <= HALFW'(LAST_HALF);      // First tick opens a load window
            joy_load <= 1'b0;
            joy_clk  <= 1'b0;
            frame_sr <= '1;                     // All buttons released
            joy1     <= '0;
            joy2     <= '0;
        end
        else
        begin
            div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
            if (half_tick)
            begin
                half_cnt <= half_nxt;
                joy_load <= half_nxt < HALFW'(2);                   // One full clock period
                joy_clk  <= (half_nxt >= HALFW'(2)) && half_nxt[0]; // High on odd halves
                // End of a low half, sample right before joy_clk rises
                if ((half_cnt >= HALFW'(2)) && !half_cnt[0])
                    frame_sr <= {joy_data, frame_sr[JOY_BITS-1:1]};
                if (half_cnt == HALFW'(LAST_HALF))
                begin
                    joy1 <= joy_state_t'(~frame_sr[PBITS-1:0]);         // Pins active low
                    joy2 <= joy_state_t'(~frame_sr[JOY_BITS-1:PBITS]);
                end
            end
        end
    end

endmodule

// File: rtl/base_pkg.sv
// Board base types shared by joystick, video and sync logic
package base_pkg;

    localparam int JOY_BITS = 24;           // Full DB9 frame, both players

    // One player, buttons active high
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic b1;
        logic b2;
        logic b3;
        logic b4;
        logic b5;
        logic b6;
        logic start;
        logic coin;
    } joy_state_t;

    typedef struct packed {
        logic [5:0] r;                      // Field 0, top of the word
        logic [5:0] g;
        logic [5:0] b;
    } rgb6_t;

    // Component view, same pin order as rgb6_t
    typedef struct packed {
        logic [5:0] pr;                     // On the red pins
        logic [5:0] y;                      // On the green pins
        logic [5:0] pb;                     // On the blue pins
    } ypbpr6_t;

    // Output pins seen either as RGB or as YPbPr
    typedef union packed {
        rgb6_t   rgb;
        ypbpr6_t ypbpr;
    } video_pxl_u;

    typedef struct packed {
        logic hs;
        logic vs;
    } video_sync_t;

endpackage
